//--- ocpi_config.svh
// widths and limits shared by the container RTL and its testbench, pulled in with `include
`ifndef OCPI_CONFIG_SVH
`define OCPI_CONFIG_SVH

// data word carried on the memory and stream ports
`define OCPI_DATA_W 32

// memory word address
`define OCPI_ADDR_W 14

// transfer length and burst length fields
`define OCPI_LEN_W 12

// largest read burst issued by the source, in words
`define OCPI_BURST_MAX 8

// stream buffer entries, a power of two
`define OCPI_FIFO_DEPTH 16

// control register address
`define OCPI_CTRL_ADDR_W 4

`endif

//--- ocpi_ctrl_pkg.sv
// control-plane types for the WCI register target, imported by the target and the container
`include "ocpi_config.svh"

package ocpi_ctrl_pkg;

  // WCI master command, OCP encoding
  typedef enum logic [2:0] {
    wci_cmd_idle  = 3'd0,
    wci_cmd_write = 3'd1,
    wci_cmd_read  = 3'd2
  } wci_cmd_e;

  // WCI slave response, OCP encoding
  typedef enum logic [1:0] {
    wci_resp_null = 2'd0,
    wci_resp_dva  = 2'd1,
    wci_resp_err  = 2'd3
  } wci_resp_e;

  // register map of the control target
  typedef enum logic [`OCPI_CTRL_ADDR_W-1:0] {
    reg_src_base = 'd0,
    reg_dst_base = 'd1,
    reg_length   = 'd2,
    reg_control  = 'd3,
    reg_status   = 'd4
  } wci_reg_e;

endpackage

//--- ocpi_data_pkg.sv
// data-plane types for the message and stream ports, imported by the workers and the container
package ocpi_data_pkg;

  // OCP command on message and stream ports
  typedef enum logic [2:0] {
    ocp_cmd_idle  = 3'd0,
    ocp_cmd_write = 3'd1,
    ocp_cmd_read  = 3'd2
  } ocp_cmd_e;

  // read response from memory
  typedef enum logic [1:0] {
    ocp_resp_null = 2'd0,
    ocp_resp_dva  = 2'd1
  } ocp_resp_e;

  typedef enum logic [1:0] {
    src_idle    = 2'd0,
    src_request = 2'd1,
    src_receive = 2'd2
  } source_state_e;

  typedef enum logic {
    snk_idle = 1'b0,
    snk_run  = 1'b1
  } sink_state_e;

endpackage

//--- wci_target.sv
// control register target that sets up a copy, issues start and reports progress
`include "ocpi_config.svh"

module wci_target import ocpi_ctrl_pkg::*; (
  input  logic                         CLK,
  input  logic                         rst_n,
  input  wci_cmd_e                     wci_mcmd,
  input  logic [`OCPI_CTRL_ADDR_W-1:0] wci_maddr,
  input  logic [`OCPI_DATA_W-1:0]      wci_mdata,
  output wci_resp_e                    wci_sresp,
  output logic [`OCPI_DATA_W-1:0]      wci_sdata,
  input  logic [`OCPI_LEN_W-1:0]       word_count,
  input  logic                         done,
  output logic                         start,
  output logic [`OCPI_ADDR_W-1:0]      src_base,
  output logic [`OCPI_LEN_W-1:0]       length,
  output logic [`OCPI_ADDR_W-1:0]      dst_base
);

  logic                    busy;
  logic                    running;
  logic                    is_write;
  logic                    is_read;
  logic                    ok;
  logic                    go;
  logic [`OCPI_DATA_W-1:0] rd_data;
  logic [`OCPI_DATA_W-1:0] status_word;

  assign is_write = (wci_mcmd == wci_cmd_write);
  assign is_read  = (wci_mcmd == wci_cmd_read);
  // start already issued but busy not yet set
  assign running  = busy | start;

  // status: count in the low bits, done at 16, busy at 17
  always_comb begin
    status_word = '0;
    status_word[`OCPI_LEN_W-1:0] = word_count;
    status_word[16] = done;
    status_word[17] = running;
  end

  // address decode and error check
  always_comb begin
    ok      = 1'b1;
    go      = 1'b0;
    rd_data = '0;
    case (wci_maddr)
      reg_src_base: rd_data[`OCPI_ADDR_W-1:0] = src_base;
      reg_dst_base: rd_data[`OCPI_ADDR_W-1:0] = dst_base;
      reg_length: begin
        rd_data[`OCPI_LEN_W-1:0] = length;
        if (is_write && wci_mdata[`OCPI_LEN_W-1:0] == '0) begin
          ok = 1'b0;
        end
      end
      reg_control: begin
        rd_data[0] = running;
        if (is_write) begin
          if (running) begin
            ok = 1'b0;
          end else begin
            go = wci_mdata[0];
          end
        end
      end
      reg_status: begin
        rd_data = status_word;
        // status is read only
        if (is_write) begin
          ok = 1'b0;
        end
      end
      default: ok = 1'b0;
    endcase
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      wci_sresp <= wci_resp_null;
      wci_sdata <= '0;
      start     <= 1'b0;
      busy      <= 1'b0;
      src_base  <= '0;
      dst_base  <= '0;
      length    <= `OCPI_LEN_W'(1);
    end else begin
      start     <= 1'b0;
      wci_sresp <= wci_resp_null;
      if (start) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;
      end
      if (wci_mcmd != wci_cmd_idle) begin
        wci_sresp <= ok ? wci_resp_dva : wci_resp_err;
        if (is_read) begin
          wci_sdata <= rd_data;
        end
        if (is_write && ok) begin
          case (wci_maddr)
            reg_src_base: src_base <= wci_mdata[`OCPI_ADDR_W-1:0];
            reg_dst_base: dst_base <= wci_mdata[`OCPI_ADDR_W-1:0];
            reg_length:   length   <= wci_mdata[`OCPI_LEN_W-1:0];
            reg_control:  start    <= go;
            default: ;
          endcase
        end
      end
    end
  end

  // one transfer at a time
  a_start_idle: assert property (@(posedge CLK) disable iff (!rst_n) start |-> !busy);

  // the sink drops its done flag as the new transfer begins
  a_done_clears: assert property (@(posedge CLK) disable iff (!rst_n)
    start |=> busy && !done);

endmodule

//--- wmi_source.sv
// memory read adapter: fetches a transfer in bursts and streams each word into the FIFO
`include "ocpi_config.svh"

module wmi_source import ocpi_data_pkg::*; (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  logic                    start,
  input  logic [`OCPI_ADDR_W-1:0] src_base,
  input  logic [`OCPI_LEN_W-1:0]  length,
  output ocp_cmd_e                wmi0_mcmd,
  output logic [`OCPI_ADDR_W-1:0] wmi0_maddr,
  output logic [`OCPI_LEN_W-1:0]  wmi0_mburst_length,
  input  ocp_resp_e               wmi0_sresp,
  input  logic [`OCPI_DATA_W-1:0] wmi0_sdata,
  input  logic                    wmi0_sresp_last,
  input  logic                    wmi0_sthread_busy,
  output ocp_cmd_e                in_mcmd,
  output logic [`OCPI_DATA_W-1:0] in_mdata,
  output logic                    in_mreq_last,
  input  logic                    in_sthread_busy
);

  source_state_e           state;
  logic [`OCPI_ADDR_W-1:0] rd_addr;
  logic [`OCPI_LEN_W-1:0]  req_left;
  logic [`OCPI_LEN_W-1:0]  rx_left;
  logic [`OCPI_LEN_W-1:0]  burst_len;
  logic                    req_go;
  logic                    req_taken;
  logic                    word_in;

  assign burst_len = (req_left > `OCPI_LEN_W'(`OCPI_BURST_MAX)) ?
                     `OCPI_LEN_W'(`OCPI_BURST_MAX) : req_left;

  // FIFO only drains while we wait here, so once raised the request stays up
  assign req_go    = (state == src_request) && !in_sthread_busy;
  assign req_taken = req_go && !wmi0_sthread_busy;
  assign word_in   = (state == src_receive) && (wmi0_sresp == ocp_resp_dva);

  assign wmi0_mcmd          = req_go ? ocp_cmd_read : ocp_cmd_idle;
  assign wmi0_maddr         = rd_addr;
  assign wmi0_mburst_length = burst_len;

  // returned words go straight onto the stream
  assign in_mcmd      = word_in ? ocp_cmd_write : ocp_cmd_idle;
  assign in_mdata     = wmi0_sdata;
  assign in_mreq_last = word_in && (rx_left == `OCPI_LEN_W'(1));

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state    <= src_idle;
      rd_addr  <= '0;
      req_left <= '0;
      rx_left  <= '0;
    end else begin
      case (state)
        src_idle: begin
          if (start) begin
            rd_addr  <= src_base;
            req_left <= length;
            rx_left  <= length;
            state    <= src_request;
          end
        end
        src_request: begin
          if (req_taken) begin
            rd_addr  <= rd_addr + `OCPI_ADDR_W'(burst_len);
            req_left <= req_left - burst_len;
            state    <= src_receive;
          end
        end
        src_receive: begin
          if (word_in) begin
            rx_left <= rx_left - `OCPI_LEN_W'(1);
            if (rx_left == `OCPI_LEN_W'(1)) begin
              state <= src_idle;
            end else if (wmi0_sresp_last) begin
              state <= src_request;
            end
          end
        end
        default: state <= src_idle;
      endcase
    end
  end

  // memory must stay quiet until a burst has been requested
  a_no_stray_dva: assert property (@(posedge CLK) disable iff (!rst_n)
    (state == src_idle) |-> (wmi0_sresp != ocp_resp_dva));

endmodule

//--- stream_fifo.sv
// stream buffer between the two adapters, signalling thread-busy when a full burst no longer fits
`include "ocpi_config.svh"

module stream_fifo import ocpi_data_pkg::*; (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  ocp_cmd_e                in_mcmd,
  input  logic [`OCPI_DATA_W-1:0] in_mdata,
  input  logic                    in_mreq_last,
  output logic                    in_sthread_busy,
  output ocp_cmd_e                out_mcmd,
  output logic [`OCPI_DATA_W-1:0] out_mdata,
  output logic                    out_mreq_last,
  input  logic                    out_sthread_busy
);

  localparam int DEPTH = `OCPI_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  // each entry keeps the last marker above the data
  logic [`OCPI_DATA_W:0] mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;
  logic                  push;
  logic                  pop;

  assign push = (in_mcmd == ocp_cmd_write);
  assign pop  = (out_mcmd == ocp_cmd_write) && !out_sthread_busy;

  assign out_mcmd      = (count != '0) ? ocp_cmd_write : ocp_cmd_idle;
  assign out_mdata     = mem[rd_ptr][`OCPI_DATA_W-1:0];
  assign out_mreq_last = mem[rd_ptr][`OCPI_DATA_W];

  // busy whenever a whole burst would not fit
  assign in_sthread_busy = (CNT_W'(DEPTH) - count) < CNT_W'(`OCPI_BURST_MAX);

  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr] <= {in_mreq_last, in_mdata};
    end
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  a_no_overflow: assert property (@(posedge CLK) disable iff (!rst_n)
    push |-> (count != CNT_W'(DEPTH)));

endmodule

//--- wmi_sink.sv
// memory write adapter: writes each streamed word to consecutive addresses and flags completion
`include "ocpi_config.svh"

module wmi_sink import ocpi_data_pkg::*; (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  logic                    start,
  input  logic [`OCPI_ADDR_W-1:0] dst_base,
  input  ocp_cmd_e                out_mcmd,
  input  logic [`OCPI_DATA_W-1:0] out_mdata,
  input  logic                    out_mreq_last,
  output logic                    out_sthread_busy,
  output ocp_cmd_e                wmi1_mcmd,
  output logic [`OCPI_ADDR_W-1:0] wmi1_maddr,
  output logic [`OCPI_DATA_W-1:0] wmi1_mdata,
  input  logic                    wmi1_sthread_busy,
  output logic [`OCPI_LEN_W-1:0]  word_count,
  output logic                    done
);

  sink_state_e             state;
  logic                    wr_valid;
  logic [`OCPI_DATA_W-1:0] wr_data;
  logic                    wr_last;
  logic                    take;
  logic                    written;

  // one word held at a time
  assign out_sthread_busy = (state != snk_run) || wr_valid;
  assign take    = (out_mcmd == ocp_cmd_write) && !out_sthread_busy;
  assign written = wr_valid && !wmi1_sthread_busy;

  assign wmi1_mcmd  = wr_valid ? ocp_cmd_write : ocp_cmd_idle;
  assign wmi1_maddr = dst_base + `OCPI_ADDR_W'(word_count);
  assign wmi1_mdata = wr_data;

  always_ff @(posedge CLK) begin
    if (take) begin
      wr_data <= out_mdata;
      wr_last <= out_mreq_last;
    end
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state      <= snk_idle;
      wr_valid   <= 1'b0;
      word_count <= '0;
      done       <= 1'b0;
    end else begin
      if (take) begin
        wr_valid <= 1'b1;
      end else if (written) begin
        wr_valid <= 1'b0;
      end
      case (state)
        snk_idle: begin
          if (start) begin
            word_count <= '0;
            done       <= 1'b0;
            state      <= snk_run;
          end
        end
        snk_run: begin
          if (written) begin
            word_count <= word_count + 1'b1;
            if (wr_last) begin
              done  <= 1'b1;
              state <= snk_idle;
            end
          end
        end
        default: state <= snk_idle;
      endcase
    end
  end

  // stalled write keeps its word and address
  a_hold_write: assert property (@(posedge CLK) disable iff (!rst_n)
    (wmi1_mcmd == ocp_cmd_write) && wmi1_sthread_busy |=>
      (wmi1_mcmd == ocp_cmd_write) && $stable(wmi1_mdata) && $stable(wmi1_maddr));

endmodule

//--- ocpi_container.sv
// container top: control target plus read adapter, stream FIFO and write adapter in a chain
`include "ocpi_config.svh"

module ocpi_container import ocpi_ctrl_pkg::*, ocpi_data_pkg::*; (
  input  logic                         CLK,
  input  logic                         rst_n,
  input  wci_cmd_e                     wci_mcmd,
  input  logic [`OCPI_CTRL_ADDR_W-1:0] wci_maddr,
  input  logic [`OCPI_DATA_W-1:0]      wci_mdata,
  output wci_resp_e                    wci_sresp,
  output logic [`OCPI_DATA_W-1:0]      wci_sdata,
  output ocp_cmd_e                     wmi0_mcmd,
  output logic [`OCPI_ADDR_W-1:0]      wmi0_maddr,
  output logic [`OCPI_LEN_W-1:0]       wmi0_mburst_length,
  input  ocp_resp_e                    wmi0_sresp,
  input  logic [`OCPI_DATA_W-1:0]      wmi0_sdata,
  input  logic                         wmi0_sresp_last,
  input  logic                         wmi0_sthread_busy,
  output ocp_cmd_e                     wmi1_mcmd,
  output logic [`OCPI_ADDR_W-1:0]      wmi1_maddr,
  output logic [`OCPI_DATA_W-1:0]      wmi1_mdata,
  input  logic                         wmi1_sthread_busy
);

  // control to workers
  logic                    start;
  logic [`OCPI_ADDR_W-1:0] src_base;
  logic [`OCPI_LEN_W-1:0]  length;
  logic [`OCPI_ADDR_W-1:0] dst_base;
  logic [`OCPI_LEN_W-1:0]  word_count;
  logic                    done;

  // source to FIFO
  ocp_cmd_e                in_mcmd;
  logic [`OCPI_DATA_W-1:0] in_mdata;
  logic                    in_mreq_last;
  logic                    in_sthread_busy;

  // FIFO to sink
  ocp_cmd_e                out_mcmd;
  logic [`OCPI_DATA_W-1:0] out_mdata;
  logic                    out_mreq_last;
  logic                    out_sthread_busy;

  wci_target wci_target_i (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .wci_mcmd   (wci_mcmd),
    .wci_maddr  (wci_maddr),
    .wci_mdata  (wci_mdata),
    .wci_sresp  (wci_sresp),
    .wci_sdata  (wci_sdata),
    .word_count (word_count),
    .done       (done),
    .start      (start),
    .src_base   (src_base),
    .length     (length),
    .dst_base   (dst_base)
  );

  wmi_source wmi_source_i (
    .CLK                (CLK),
    .rst_n              (rst_n),
    .start              (start),
    .src_base           (src_base),
    .length             (length),
    .wmi0_mcmd          (wmi0_mcmd),
    .wmi0_maddr         (wmi0_maddr),
    .wmi0_mburst_length (wmi0_mburst_length),
    .wmi0_sresp         (wmi0_sresp),
    .wmi0_sdata         (wmi0_sdata),
    .wmi0_sresp_last    (wmi0_sresp_last),
    .wmi0_sthread_busy  (wmi0_sthread_busy),
    .in_mcmd            (in_mcmd),
    .in_mdata           (in_mdata),
    .in_mreq_last       (in_mreq_last),
    .in_sthread_busy    (in_sthread_busy)
  );

  stream_fifo stream_fifo_i (
    .CLK              (CLK),
    .rst_n            (rst_n),
    .in_mcmd          (in_mcmd),
    .in_mdata         (in_mdata),
    .in_mreq_last     (in_mreq_last),
    .in_sthread_busy  (in_sthread_busy),
    .out_mcmd         (out_mcmd),
    .out_mdata        (out_mdata),
    .out_mreq_last    (out_mreq_last),
    .out_sthread_busy (out_sthread_busy)
  );

  wmi_sink wmi_sink_i (
    .CLK               (CLK),
    .rst_n             (rst_n),
    .start             (start),
    .dst_base          (dst_base),
    .out_mcmd          (out_mcmd),
    .out_mdata         (out_mdata),
    .out_mreq_last     (out_mreq_last),
    .out_sthread_busy  (out_sthread_busy),
    .wmi1_mcmd         (wmi1_mcmd),
    .wmi1_maddr        (wmi1_maddr),
    .wmi1_mdata        (wmi1_mdata),
    .wmi1_sthread_busy (wmi1_sthread_busy),
    .word_count        (word_count),
    .done              (done)
  );

endmodule

//--- tb_ocpi_container.sv
// testbench that drives the container through a table of copy tests against two memory models
`include "ocpi_config.svh"

module tb_ocpi_container import ocpi_ctrl_pkg::*, ocpi_data_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_TESTS = 7;
  localparam int MEM_WORDS = 1 << `OCPI_ADDR_W;

  logic                         CLK;
  logic                         rst_n;
  wci_cmd_e                     wci_mcmd;
  logic [`OCPI_CTRL_ADDR_W-1:0] wci_maddr;
  logic [`OCPI_DATA_W-1:0]      wci_mdata;
  wci_resp_e                    wci_sresp;
  logic [`OCPI_DATA_W-1:0]      wci_sdata;
  ocp_cmd_e                     wmi0_mcmd;
  logic [`OCPI_ADDR_W-1:0]      wmi0_maddr;
  logic [`OCPI_LEN_W-1:0]       wmi0_mburst_length;
  ocp_resp_e                    wmi0_sresp;
  logic [`OCPI_DATA_W-1:0]      wmi0_sdata;
  logic                         wmi0_sresp_last;
  logic                         wmi0_sthread_busy;
  ocp_cmd_e                     wmi1_mcmd;
  logic [`OCPI_ADDR_W-1:0]      wmi1_maddr;
  logic [`OCPI_DATA_W-1:0]      wmi1_mdata;
  logic                         wmi1_sthread_busy;

  // memory models
  logic [`OCPI_DATA_W-1:0] src_mem [MEM_WORDS];
  logic [`OCPI_DATA_W-1:0] dst_mem [MEM_WORDS];
  int                      writes_seen;
  int                      busy_left;
  logic                    long_busy;
  logic                    long_now;
  int                      cur_test;
  logic [`OCPI_ADDR_W-1:0] rd_next;

  // test table with one row per test
  string                   t_name [NUM_TESTS];
  logic [`OCPI_ADDR_W-1:0] t_src  [NUM_TESTS];
  logic [`OCPI_ADDR_W-1:0] t_dst  [NUM_TESTS];
  logic [`OCPI_LEN_W-1:0]  t_len  [NUM_TESTS];
  wci_resp_e               t_resp [NUM_TESTS];
  logic                    t_long [NUM_TESTS];
  logic                    t_poke [NUM_TESTS];

  ocpi_container ocpi_container_i (
    .CLK                (CLK),
    .rst_n              (rst_n),
    .wci_mcmd           (wci_mcmd),
    .wci_maddr          (wci_maddr),
    .wci_mdata          (wci_mdata),
    .wci_sresp          (wci_sresp),
    .wci_sdata          (wci_sdata),
    .wmi0_mcmd          (wmi0_mcmd),
    .wmi0_maddr         (wmi0_maddr),
    .wmi0_mburst_length (wmi0_mburst_length),
    .wmi0_sresp         (wmi0_sresp),
    .wmi0_sdata         (wmi0_sdata),
    .wmi0_sresp_last    (wmi0_sresp_last),
    .wmi0_sthread_busy  (wmi0_sthread_busy),
    .wmi1_mcmd          (wmi1_mcmd),
    .wmi1_maddr         (wmi1_maddr),
    .wmi1_mdata         (wmi1_mdata),
    .wmi1_sthread_busy  (wmi1_sthread_busy)
  );

  always #4 CLK = ~CLK;

  function automatic logic [`OCPI_DATA_W-1:0] fill_word(input int a);
    logic [`OCPI_ADDR_W-1:0] w;
    w = a[`OCPI_ADDR_W-1:0];
    return {2'b10, w, ~w, 2'b01};
  endfunction

  task automatic add_row(input int i, input string name, input int src, input int dst,
                         input int len, input wci_resp_e resp, input logic lb, input logic pk);
    t_name[i] = name;
    t_src[i]  = src[`OCPI_ADDR_W-1:0];
    t_dst[i]  = dst[`OCPI_ADDR_W-1:0];
    t_len[i]  = len[`OCPI_LEN_W-1:0];
    t_resp[i] = resp;
    t_long[i] = lb;
    t_poke[i] = pk;
  endtask

  task automatic check_resp(input string name, input wci_resp_e exp, input wci_resp_e act);
    if (exp !== act) begin
      $display("mismatch %s: response expected %s actual %s", name, exp.name(), act.name());
      $display("Done: errors found");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic check_word(input string name, input logic [`OCPI_DATA_W-1:0] exp,
                            input logic [`OCPI_DATA_W-1:0] act);
    if (exp !== act) begin
      $display("mismatch %s: word expected %h actual %h", name, exp, act);
      $display("Done: errors found");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic check_status(input string name, input logic [`OCPI_DATA_W-1:0] exp,
                              input logic [`OCPI_DATA_W-1:0] act);
    if (exp !== act) begin
      $display("mismatch %s: status expected %h actual %h", name, exp, act);
      $display("Done: errors found");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic check_addr(input string name, input logic [`OCPI_ADDR_W-1:0] exp,
                            input logic [`OCPI_ADDR_W-1:0] act);
    if (exp !== act) begin
      $display("mismatch %s: read address expected %h actual %h", name, exp, act);
      $display("Done: errors found");
      $fatal(1, "stopping at first error");
    end
  endtask

  // one control access with the response sampled just after the edge that took it
  task automatic ctrl_access(input wci_cmd_e cmd, input logic [`OCPI_CTRL_ADDR_W-1:0] addr,
                             input logic [`OCPI_DATA_W-1:0] data, output wci_resp_e resp,
                             output logic [`OCPI_DATA_W-1:0] rdata);
    wci_mcmd  = cmd;
    wci_maddr = addr;
    wci_mdata = data;
    @(posedge CLK);
    #1;
    wci_mcmd = wci_cmd_idle;
    resp     = wci_sresp;
    rdata    = wci_sdata;
  endtask

  task automatic reg_write(input string name, input logic [`OCPI_CTRL_ADDR_W-1:0] addr,
                           input logic [`OCPI_DATA_W-1:0] data, input wci_resp_e exp);
    wci_resp_e               resp;
    logic [`OCPI_DATA_W-1:0] rdata;
    ctrl_access(wci_cmd_write, addr, data, resp, rdata);
    check_resp(name, exp, resp);
  endtask

  task automatic reg_read(input string name, input logic [`OCPI_CTRL_ADDR_W-1:0] addr,
                          output logic [`OCPI_DATA_W-1:0] rdata);
    wci_resp_e resp;
    ctrl_access(wci_cmd_read, addr, '0, resp, rdata);
    check_resp(name, wci_resp_dva, resp);
  endtask

  task automatic run_copy(input int i);
    logic [`OCPI_DATA_W-1:0] rd;
    writes_seen = 0;
    rd_next     = t_src[i];
    reg_write(t_name[i], reg_control, 32'd1, wci_resp_dva);
    // let start reach the sink before looking at status
    @(posedge CLK);
    #1;
    reg_read(t_name[i], reg_status, rd);
    check_status(t_name[i], 32'h0002_0000, rd);
    if (t_poke[i]) begin
      reg_write(t_name[i], reg_control, 32'd1, wci_resp_err);
      reg_write(t_name[i], reg_status, 32'd0, wci_resp_err);
      reg_write(t_name[i], 4'd9, 32'd0, wci_resp_err);
    end
    rd = '0;
    while (!rd[16]) begin
      reg_read(t_name[i], reg_status, rd);
    end
    // busy drops one cycle behind done
    reg_read(t_name[i], reg_status, rd);
    check_status(t_name[i], 32'h0001_0000 | 32'(t_len[i]), rd);
    check_word(t_name[i], 32'(t_len[i]), 32'(writes_seen));
    for (int k = 0; k < t_len[i]; k++) begin
      check_word(t_name[i], src_mem[t_src[i] + `OCPI_ADDR_W'(k)],
                 dst_mem[t_dst[i] + `OCPI_ADDR_W'(k)]);
    end
    check_word(t_name[i], fill_word(t_dst[i] + t_len[i]), dst_mem[t_dst[i] + t_len[i]]);
  endtask

  // read memory with a random start gap and random gaps between words
  initial begin : read_model
    logic [`OCPI_ADDR_W-1:0] addr;
    logic [`OCPI_LEN_W-1:0]  len;
    int                      gap;
    forever begin
      @(posedge CLK);
      if (wmi0_mcmd == ocp_cmd_read && !wmi0_sthread_busy) begin
        addr = wmi0_maddr;
        len  = wmi0_mburst_length;
        // bursts follow each other upward from the source base
        check_addr(t_name[cur_test], rd_next, addr);
        if (len == '0 || len > `OCPI_LEN_W'(`OCPI_BURST_MAX)) begin
          $display("read burst of %0d words in %s is outside 1 to %0d words",
                   len, t_name[cur_test], `OCPI_BURST_MAX);
          $display("Done: errors found");
          $fatal(1, "stopping at first error");
        end
        rd_next = addr + `OCPI_ADDR_W'(len);
        gap     = $urandom_range(0, 3);
        repeat (gap) @(posedge CLK);
        #1;
        for (int k = 0; k < len; k++) begin
          wmi0_sresp      = ocp_resp_dva;
          wmi0_sdata      = src_mem[addr + `OCPI_ADDR_W'(k)];
          wmi0_sresp_last = (k == len - 1);
          @(posedge CLK);
          #1;
          wmi0_sresp      = ocp_resp_null;
          wmi0_sresp_last = 1'b0;
          // no gap after the last word so the next request is seen at once
          if (k < len - 1) begin
            gap = $urandom_range(0, 2);
            repeat (gap) begin
              @(posedge CLK);
              #1;
            end
          end
        end
      end
    end
  end

  // write memory keeping every accepted write, with sparse or long busy runs
  always begin : write_model
    @(posedge CLK);
    long_now = long_busy;
    if (wmi1_mcmd == ocp_cmd_write && !wmi1_sthread_busy) begin
      dst_mem[wmi1_maddr] = wmi1_mdata;
      writes_seen++;
    end
    #1;
    if (busy_left != 0) begin
      busy_left--;
    end else if (long_now) begin
      wmi1_sthread_busy = !wmi1_sthread_busy;
      busy_left = $urandom_range(1, 12);
    end else begin
      wmi1_sthread_busy = ($urandom_range(0, 3) == 0);
    end
  end

  initial begin : watchdog
    int total;
    #1;
    total = 0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      total += t_len[i];
    end
    repeat (200 + 20 * total) @(posedge CLK);
    $display("watchdog: the copies did not finish within %0d cycles", 200 + 20 * total);
    $display("Done: errors found");
    $fatal(1, "run stopped by watchdog");
  end

  initial begin : main
    logic [`OCPI_DATA_W-1:0] rd;
    CLK               = 1'b0;
    rst_n             = 1'b0;
    wci_mcmd          = wci_cmd_idle;
    wci_maddr         = '0;
    wci_mdata         = '0;
    wmi0_sresp        = ocp_resp_null;
    wmi0_sdata        = '0;
    wmi0_sresp_last   = 1'b0;
    wmi0_sthread_busy = 1'b0;
    wmi1_sthread_busy = 1'b0;
    writes_seen       = 0;
    busy_left         = 0;
    long_busy         = 1'b0;
    long_now          = 1'b0;
    cur_test          = 0;
    rd_next           = '0;
    void'($urandom(32'h0a465403));
    add_row(0, "copy_len1",    'h0100, 'h2000,  1, wci_resp_dva, 1'b0, 1'b0);
    add_row(1, "copy_len8",    'h0200, 'h2100,  8, wci_resp_dva, 1'b0, 1'b0);
    add_row(2, "copy_len9",    'h0300, 'h2200,  9, wci_resp_dva, 1'b0, 1'b0);
    add_row(3, "copy_len40",   'h0400, 'h2300, 40, wci_resp_dva, 1'b0, 1'b0);
    add_row(4, "zero_length",  'h0480, 'h2380,  0, wci_resp_err, 1'b0, 1'b0);
    add_row(5, "backpressure", 'h0500, 'h2400, 40, wci_resp_dva, 1'b1, 1'b0);
    add_row(6, "errors_busy",  'h0600, 'h2500, 40, wci_resp_dva, 1'b0, 1'b1);
    for (int a = 0; a < MEM_WORDS; a++) begin
      src_mem[a] = $urandom;
      dst_mem[a] = fill_word(a);
    end
    repeat (16) @(posedge CLK);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < NUM_TESTS; i++) begin
      cur_test  = i;
      long_busy = t_long[i];
      reg_write(t_name[i], reg_src_base, 32'(t_src[i]), wci_resp_dva);
      reg_write(t_name[i], reg_dst_base, 32'(t_dst[i]), wci_resp_dva);
      reg_write(t_name[i], reg_length, 32'(t_len[i]), t_resp[i]);
      if (t_resp[i] == wci_resp_dva) begin
        reg_read(t_name[i], reg_src_base, rd);
        check_word(t_name[i], 32'(t_src[i]), rd);
        reg_read(t_name[i], reg_dst_base, rd);
        check_word(t_name[i], 32'(t_dst[i]), rd);
        reg_read(t_name[i], reg_length, rd);
        check_word(t_name[i], 32'(t_len[i]), rd);
        run_copy(i);
      end
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

//--- list.f
+incdir+.
ocpi_ctrl_pkg.sv
ocpi_data_pkg.sv
wci_target.sv
wmi_source.sv
stream_fifo.sv
wmi_sink.sv
ocpi_container.sv
tb_ocpi_container.sv

//--- Bender.yml
package:
  name: ocpi_container

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - ocpi_ctrl_pkg.sv
      - ocpi_data_pkg.sv
      - wci_target.sv
      - wmi_source.sv
      - stream_fifo.sv
      - wmi_sink.sv
      - ocpi_container.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ocpi_container.sv
